// File: dwc_defs.svh
/* Width and limit macros for the 64-to-32 bit AXI write downsizer.
   Included by the package, the RTL modules and the testbench. */

`ifndef DWC_DEFS_SVH
`define DWC_DEFS_SVH

// Address and transaction ID
`define DWC_ADDR_W 32
`define DWC_ID_W 4

// Slave side is the wide port
`define DWC_SI_DATA_W 64
`define DWC_MI_DATA_W 32

// Byte lanes per data beat
`define DWC_SI_BYTES 8
`define DWC_MI_BYTES 4

// AXI4 INCR burst limit in beats
`define DWC_MAX_BEATS 256

`endif

// File: dwc_pkg.sv
/* Shared AXI field types and FSM encodings for the write downsizer.
   Imported by wildcard in the module headers. */

`include "dwc_defs.svh"

package dwc_pkg;

  typedef logic [`DWC_ADDR_W-1:0] addr_t;
  typedef logic [`DWC_ID_W-1:0]   id_t;
  typedef logic [7:0]             len_t;
  typedef logic [2:0]             size_t;
  typedef logic [1:0]             resp_t;

  // Narrow length minus one, up to 512 beats for a 2:1 ratio
  typedef logic [9:0] full_len_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    DW_IDLE,
    DW_PASSTHROUGH,
    DW_INCR_DOWNSIZE,
    DW_SPLIT_DOWNSIZE
  } dw_state_e;

  // AxCACHE bit 1
  localparam logic [3:0] CACHE_MODIFIABLE = 4'b0010;

endpackage

// File: dwc_aw_decode.sv
/* First stage of the write downsizer. Accepts a slave AW, works out the
   conversion mode and narrow lengths, and holds them for burst control. */

`timescale 1ns/1ps
`include "dwc_defs.svh"

module dwc_aw_decode import dwc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  id_t       slv_aw_id_i,
  input  addr_t     slv_aw_addr_i,
  input  len_t      slv_aw_len_i,
  input  size_t     slv_aw_size_i,
  input  burst_e    slv_aw_burst_i,
  input  logic [3:0] slv_aw_cache_i,
  input  logic      slv_aw_valid_i,
  output logic      slv_aw_ready_o,
  input  logic      dec_take_i,
  output logic      dec_valid_o,
  output id_t       dec_id_o,
  output addr_t     dec_addr_o,
  output size_t     dec_size_o,
  output burst_e    dec_burst_o,
  output len_t      dec_first_len_o,
  output full_len_t dec_total_len_o,
  output dw_state_e dec_mode_o
);

  localparam size_t wide_size   = size_t'($clog2(`DWC_SI_BYTES));
  localparam size_t narrow_size = size_t'($clog2(`DWC_MI_BYTES));
  localparam len_t  max_len     = len_t'(`DWC_MAX_BEATS - 1);

  logic      downsize;
  logic      adj;
  full_len_t total_len;
  len_t      first_len;
  dw_state_e mode;
  logic      aw_hs;
  logic      valid_q;

  // --------------------------------------------------
  // Length and mode decode
  // --------------------------------------------------
  always_comb begin
    downsize = (|(slv_aw_cache_i & CACHE_MODIFIABLE)) && (slv_aw_burst_i == BURST_INCR) &&
               (slv_aw_size_i == wide_size);
    // Start in the upper half of a wide word drops one narrow beat
    adj = downsize && slv_aw_addr_i[$clog2(`DWC_MI_BYTES)];

    if (downsize) begin
      // 2*(len+1) - adj - 1
      total_len = {1'b0, slv_aw_len_i, 1'b1} - full_len_t'(adj);
      if (total_len < `DWC_MAX_BEATS) begin
        mode      = DW_INCR_DOWNSIZE;
        first_len = total_len[7:0];
      end else begin
        mode      = DW_SPLIT_DOWNSIZE;
        first_len = max_len - len_t'(adj);
      end
    end else begin
      mode      = DW_PASSTHROUGH;
      total_len = full_len_t'(slv_aw_len_i);
      first_len = slv_aw_len_i;
    end
  end

  // --------------------------------------------------
  // One-entry holding register
  // --------------------------------------------------
  assign slv_aw_ready_o = !valid_q;
  assign aw_hs          = slv_aw_valid_i && slv_aw_ready_o;
  assign dec_valid_o    = valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (aw_hs) begin
      valid_q <= 1'b1;
    end else if (dec_take_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      dec_id_o        <= slv_aw_id_i;
      dec_addr_o      <= slv_aw_addr_i;
      dec_size_o      <= downsize ? narrow_size : slv_aw_size_i;
      dec_burst_o     <= slv_aw_burst_i;
      dec_first_len_o <= first_len;
      dec_total_len_o <= total_len;
      dec_mode_o      <= mode;
    end
  end

endmodule

// File: dwc_burst_ctrl.sv
/* Second stage of the write downsizer. Issues master AW requests, splits long
   narrow bursts, tracks the beat address and decides slave W acceptance. */

`timescale 1ns/1ps
`include "dwc_defs.svh"

module dwc_burst_ctrl import dwc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      dec_valid_i,
  input  id_t       dec_id_i,
  input  addr_t     dec_addr_i,
  input  size_t     dec_size_i,
  input  burst_e    dec_burst_i,
  input  len_t      dec_first_len_i,
  input  full_len_t dec_total_len_i,
  input  dw_state_e dec_mode_i,
  output logic      dec_take_o,
  output id_t       mst_aw_id_o,
  output addr_t     mst_aw_addr_o,
  output len_t      mst_aw_len_o,
  output size_t     mst_aw_size_o,
  output burst_e    mst_aw_burst_o,
  output logic      mst_aw_valid_o,
  input  logic      mst_aw_ready_i,
  input  logic      slv_w_valid_i,
  input  logic      slv_w_last_i,
  output logic      mst_w_valid_o,
  output logic      mst_w_last_o,
  input  logic      mst_w_ready_i,
  output logic      slv_w_ready_o,
  output addr_t     cur_addr_o,
  output size_t     slv_size_o
);

  localparam size_t wide_size = size_t'($clog2(`DWC_SI_BYTES));
  localparam len_t  max_len   = len_t'(`DWC_MAX_BEATS - 1);

  dw_state_e state_q;
  logic      aw_valid_q;
  full_len_t total_q;
  len_t      aw_len_q;
  id_t       id_q;
  addr_t     addr_q;
  size_t     size_q;
  size_t     slv_size_q;
  burst_e    burst_q;

  logic      w_en;
  logic      w_hs;
  logic      beat_done;
  addr_t     size_mask;
  addr_t     wide_mask;
  addr_t     next_addr;
  full_len_t total_nxt;

  assign dec_take_o = (state_q == DW_IDLE) && dec_valid_i;

  assign mst_aw_id_o    = id_q;
  assign mst_aw_addr_o  = addr_q;
  assign mst_aw_len_o   = aw_len_q;
  assign mst_aw_size_o  = size_q;
  assign mst_aw_burst_o = burst_q;
  assign mst_aw_valid_o = aw_valid_q;
  assign cur_addr_o     = addr_q;
  assign slv_size_o     = slv_size_q;

  // --------------------------------------------------
  // W path, open once the current AW is granted
  // --------------------------------------------------
  assign w_en          = (state_q != DW_IDLE) && !aw_valid_q;
  assign mst_w_valid_o = w_en && slv_w_valid_i;
  assign mst_w_last_o  = mst_w_valid_o && slv_w_last_i && (total_q == '0);
  assign w_hs          = mst_w_valid_o && mst_w_ready_i;

  always_comb begin
    size_mask = (addr_t'(1) << size_q) - addr_t'(1);
    wide_mask = (addr_t'(1) << slv_size_q) - addr_t'(1);
    next_addr = (addr_q & ~size_mask) + (addr_t'(1) << size_q);
    total_nxt = total_q - full_len_t'(1);
    // Wide beat is done when the next narrow beat leaves its aligned word
    if (state_q == DW_PASSTHROUGH) begin
      beat_done = 1'b1;
    end else begin
      beat_done = (total_q == '0) || ((next_addr & ~wide_mask) != (addr_q & ~wide_mask));
    end
  end

  assign slv_w_ready_o = w_hs && beat_done;

  // --------------------------------------------------
  // Burst FSM
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= DW_IDLE;
      aw_valid_q <= 1'b0;
      total_q    <= '0;
      aw_len_q   <= '0;
    end else if (state_q == DW_IDLE) begin
      if (dec_valid_i) begin
        state_q    <= dec_mode_i;
        aw_valid_q <= 1'b1;
        total_q    <= dec_total_len_i;
        aw_len_q   <= dec_first_len_i;
      end
    end else begin
      if (aw_valid_q && mst_aw_ready_i) begin
        aw_valid_q <= 1'b0;
      end
      if (w_hs) begin
        total_q  <= total_nxt;
        aw_len_q <= aw_len_q - len_t'(1);
        // Current master burst ended with beats still to go
        if ((state_q == DW_SPLIT_DOWNSIZE) && (aw_len_q == '0) && (total_q != '0)) begin
          aw_valid_q <= 1'b1;
          aw_len_q   <= (total_nxt < `DWC_MAX_BEATS) ? total_nxt[7:0] : max_len;
        end
        if (total_q == '0) begin
          state_q <= DW_IDLE;
        end
      end
    end
  end

  // Request payload, loaded on take and stepped per narrow beat
  always_ff @(posedge clk_i) begin
    if (dec_take_o) begin
      id_q       <= dec_id_i;
      addr_q     <= dec_addr_i;
      size_q     <= dec_size_i;
      slv_size_q <= (dec_mode_i == DW_PASSTHROUGH) ? dec_size_i : wide_size;
      burst_q    <= dec_burst_i;
    end else if (w_hs) begin
      addr_q <= next_addr;
    end
  end

endmodule

// File: dwc_w_steer.sv
/* Third stage of the write downsizer. Steers slave byte lanes and strobes
   onto the narrow master lanes using the current beat address. */

`timescale 1ns/1ps
`include "dwc_defs.svh"

module dwc_w_steer import dwc_pkg::*; (
  input  addr_t                     cur_addr_i,
  input  size_t                     slv_size_i,
  input  logic [`DWC_SI_DATA_W-1:0] slv_w_data_i,
  input  logic [`DWC_SI_BYTES-1:0]  slv_w_strb_i,
  output logic [`DWC_MI_DATA_W-1:0] mst_w_data_o,
  output logic [`DWC_MI_BYTES-1:0]  mst_w_strb_o
);

  int si_off;
  int mi_off;

  assign si_off = int'(cur_addr_i[$clog2(`DWC_SI_BYTES)-1:0]);
  assign mi_off = int'(cur_addr_i[$clog2(`DWC_MI_BYTES)-1:0]);

  always_comb begin
    int lane;
    mst_w_data_o = '0;
    mst_w_strb_o = '0;
    lane         = 0;
    for (int b = 0; b < `DWC_SI_BYTES; b++) begin
      lane = b - si_off + mi_off;
      // Only bytes of the active slave beat that land on a master lane
      if ((b >= si_off) && ((b - si_off) < (1 << slv_size_i)) &&
          (lane < `DWC_MI_BYTES)) begin
        mst_w_data_o[8*lane +: 8] = slv_w_data_i[8*b +: 8];
        mst_w_strb_o[lane]        = slv_w_strb_i[b];
      end
    end
  end

endmodule

// File: dwc_top.sv
/* Top level of the 64-to-32 bit AXI write downsizer. Chains AW decode,
   burst control and W lane steering; the B channel is passed straight through. */

`timescale 1ns/1ps
`include "dwc_defs.svh"

module dwc_top import dwc_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Slave port
  input  id_t                       slv_aw_id_i,
  input  addr_t                     slv_aw_addr_i,
  input  len_t                      slv_aw_len_i,
  input  size_t                     slv_aw_size_i,
  input  burst_e                    slv_aw_burst_i,
  input  logic [3:0]                slv_aw_cache_i,
  input  logic                      slv_aw_valid_i,
  output logic                      slv_aw_ready_o,
  input  logic [`DWC_SI_DATA_W-1:0] slv_w_data_i,
  input  logic [`DWC_SI_BYTES-1:0]  slv_w_strb_i,
  input  logic                      slv_w_last_i,
  input  logic                      slv_w_valid_i,
  output logic                      slv_w_ready_o,
  output id_t                       slv_b_id_o,
  output resp_t                     slv_b_resp_o,
  output logic                      slv_b_valid_o,
  input  logic                      slv_b_ready_i,
  // Master port
  output id_t                       mst_aw_id_o,
  output addr_t                     mst_aw_addr_o,
  output len_t                      mst_aw_len_o,
  output size_t                     mst_aw_size_o,
  output burst_e                    mst_aw_burst_o,
  output logic                      mst_aw_valid_o,
  input  logic                      mst_aw_ready_i,
  output logic [`DWC_MI_DATA_W-1:0] mst_w_data_o,
  output logic [`DWC_MI_BYTES-1:0]  mst_w_strb_o,
  output logic                      mst_w_last_o,
  output logic                      mst_w_valid_o,
  input  logic                      mst_w_ready_i,
  input  id_t                       mst_b_id_i,
  input  resp_t                     mst_b_resp_i,
  input  logic                      mst_b_valid_i,
  output logic                      mst_b_ready_o
);

  logic      dec_valid;
  logic      dec_take;
  id_t       dec_id;
  addr_t     dec_addr;
  size_t     dec_size;
  burst_e    dec_burst;
  len_t      dec_first_len;
  full_len_t dec_total_len;
  dw_state_e dec_mode;
  addr_t     cur_addr;
  size_t     slv_size;

  dwc_aw_decode u_aw_decode (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .slv_aw_id_i     (slv_aw_id_i),
    .slv_aw_addr_i   (slv_aw_addr_i),
    .slv_aw_len_i    (slv_aw_len_i),
    .slv_aw_size_i   (slv_aw_size_i),
    .slv_aw_burst_i  (slv_aw_burst_i),
    .slv_aw_cache_i  (slv_aw_cache_i),
    .slv_aw_valid_i  (slv_aw_valid_i),
    .slv_aw_ready_o  (slv_aw_ready_o),
    .dec_take_i      (dec_take),
    .dec_valid_o     (dec_valid),
    .dec_id_o        (dec_id),
    .dec_addr_o      (dec_addr),
    .dec_size_o      (dec_size),
    .dec_burst_o     (dec_burst),
    .dec_first_len_o (dec_first_len),
    .dec_total_len_o (dec_total_len),
    .dec_mode_o      (dec_mode)
  );

  dwc_burst_ctrl u_burst_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .dec_valid_i     (dec_valid),
    .dec_id_i        (dec_id),
    .dec_addr_i      (dec_addr),
    .dec_size_i      (dec_size),
    .dec_burst_i     (dec_burst),
    .dec_first_len_i (dec_first_len),
    .dec_total_len_i (dec_total_len),
    .dec_mode_i      (dec_mode),
    .dec_take_o      (dec_take),
    .mst_aw_id_o     (mst_aw_id_o),
    .mst_aw_addr_o   (mst_aw_addr_o),
    .mst_aw_len_o    (mst_aw_len_o),
    .mst_aw_size_o   (mst_aw_size_o),
    .mst_aw_burst_o  (mst_aw_burst_o),
    .mst_aw_valid_o  (mst_aw_valid_o),
    .mst_aw_ready_i  (mst_aw_ready_i),
    .slv_w_valid_i   (slv_w_valid_i),
    .slv_w_last_i    (slv_w_last_i),
    .mst_w_valid_o   (mst_w_valid_o),
    .mst_w_last_o    (mst_w_last_o),
    .mst_w_ready_i   (mst_w_ready_i),
    .slv_w_ready_o   (slv_w_ready_o),
    .cur_addr_o      (cur_addr),
    .slv_size_o      (slv_size)
  );

  dwc_w_steer u_w_steer (
    .cur_addr_i   (cur_addr),
    .slv_size_i   (slv_size),
    .slv_w_data_i (slv_w_data_i),
    .slv_w_strb_i (slv_w_strb_i),
    .mst_w_data_o (mst_w_data_o),
    .mst_w_strb_o (mst_w_strb_o)
  );

  // B responses need no conversion
  assign slv_b_id_o    = mst_b_id_i;
  assign slv_b_resp_o  = mst_b_resp_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

endmodule

// File: tb_dwc.sv
/* Testbench for the 64-to-32 bit AXI write downsizer. Reads tests from dwc_stim.txt,
   drives the slave side, acts as the master-side memory and checks each transfer. */

`timescale 1ns/1ps
`include "dwc_defs.svh"

module tb_dwc import dwc_pkg::*; ();

  localparam int HALF_PERIOD = 20;
  localparam int SETTLE      = 10;
  localparam int MAX_TESTS   = 32;

  logic clk;
  logic rst_n;

  id_t    slv_aw_id;
  addr_t  slv_aw_addr;
  len_t   slv_aw_len;
  size_t  slv_aw_size;
  burst_e slv_aw_burst;
  logic [3:0] slv_aw_cache;
  logic   slv_aw_valid, slv_aw_ready;
  logic [`DWC_SI_DATA_W-1:0] slv_w_data;
  logic [`DWC_SI_BYTES-1:0]  slv_w_strb;
  logic   slv_w_last, slv_w_valid, slv_w_ready;
  id_t    slv_b_id;
  resp_t  slv_b_resp;
  logic   slv_b_valid, slv_b_ready;

  id_t    mst_aw_id;
  addr_t  mst_aw_addr;
  len_t   mst_aw_len;
  size_t  mst_aw_size;
  burst_e mst_aw_burst;
  logic   mst_aw_valid, mst_aw_ready;
  logic [`DWC_MI_DATA_W-1:0] mst_w_data;
  logic [`DWC_MI_BYTES-1:0]  mst_w_strb;
  logic   mst_w_last, mst_w_valid, mst_w_ready;
  id_t    mst_b_id;
  resp_t  mst_b_resp;
  logic   mst_b_valid, mst_b_ready;

  // Test table
  int          n_tests;
  logic [3:0]  st_id     [MAX_TESTS];
  logic [31:0] st_addr   [MAX_TESTS];
  int          st_size   [MAX_TESTS];
  int          st_len    [MAX_TESTS];
  int          st_burst  [MAX_TESTS];
  logic [3:0]  st_cache  [MAX_TESTS];
  int          st_bp     [MAX_TESTS];
  int          st_aw_cnt [MAX_TESTS];

  // Expected master traffic of the running test
  logic [31:0] exp_aw_addr[$];
  int          exp_aw_len[$];
  logic [31:0] exp_data[$];
  logic [3:0]  exp_strb[$];
  bit          exp_last[$];
  logic [`DWC_SI_DATA_W-1:0] beat_data [`DWC_MAX_BEATS];

  integer seed        = 89;
  int     err_cnt     = 0;
  int     check_cnt   = 0;
  int     cycles      = 0;
  int     cycle_limit = 0;
  bit     limit_set   = 0;

  dwc_top u_dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .slv_aw_id_i    (slv_aw_id),
    .slv_aw_addr_i  (slv_aw_addr),
    .slv_aw_len_i   (slv_aw_len),
    .slv_aw_size_i  (slv_aw_size),
    .slv_aw_burst_i (slv_aw_burst),
    .slv_aw_cache_i (slv_aw_cache),
    .slv_aw_valid_i (slv_aw_valid),
    .slv_aw_ready_o (slv_aw_ready),
    .slv_w_data_i   (slv_w_data),
    .slv_w_strb_i   (slv_w_strb),
    .slv_w_last_i   (slv_w_last),
    .slv_w_valid_i  (slv_w_valid),
    .slv_w_ready_o  (slv_w_ready),
    .slv_b_id_o     (slv_b_id),
    .slv_b_resp_o   (slv_b_resp),
    .slv_b_valid_o  (slv_b_valid),
    .slv_b_ready_i  (slv_b_ready),
    .mst_aw_id_o    (mst_aw_id),
    .mst_aw_addr_o  (mst_aw_addr),
    .mst_aw_len_o   (mst_aw_len),
    .mst_aw_size_o  (mst_aw_size),
    .mst_aw_burst_o (mst_aw_burst),
    .mst_aw_valid_o (mst_aw_valid),
    .mst_aw_ready_i (mst_aw_ready),
    .mst_w_data_o   (mst_w_data),
    .mst_w_strb_o   (mst_w_strb),
    .mst_w_last_o   (mst_w_last),
    .mst_w_valid_o  (mst_w_valid),
    .mst_w_ready_i  (mst_w_ready),
    .mst_b_id_i     (mst_b_id),
    .mst_b_resp_i   (mst_b_resp),
    .mst_b_valid_i  (mst_b_valid),
    .mst_b_ready_o  (mst_b_ready)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Watchdog
  initial begin
    while (!(limit_set && (cycles > cycle_limit))) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic bit downsized(int t);
    return ((st_cache[t] & CACHE_MODIFIABLE) != 4'b0) && (st_burst[t] == 1) &&
           (st_size[t] == 3);
  endfunction

  function automatic int narrow_beats(int t);
    if (downsized(t)) begin
      return 2 * (st_len[t] + 1) - int'(st_addr[t][2]);
    end
    return st_len[t] + 1;
  endfunction

  task automatic build_expected(input int t);
    int          beats;
    int          aw_left;
    int          j;
    int          nbytes;
    int          sbytes;
    int          si_off;
    int          mi_off;
    int          b;
    bit          ds;
    logic [31:0] a;
    logic [31:0] nxt;
    logic [31:0] d;
    logic [3:0]  s;
    ds     = downsized(t);
    beats  = narrow_beats(t);
    nbytes = ds ? 4 : (1 << st_size[t]);
    sbytes = ds ? 8 : nbytes;
    exp_aw_addr.delete();
    exp_aw_len.delete();
    exp_data.delete();
    exp_strb.delete();
    exp_last.delete();
    a       = st_addr[t];
    j       = 0;
    aw_left = 0;
    for (int k = 0; k < beats; k++) begin
      if (aw_left == 0) begin
        // First split burst stops one beat short for an upper-half start
        if ((k == 0) && ds) begin
          aw_left = (beats < 256 - int'(a[2])) ? beats : 256 - int'(a[2]);
        end else begin
          aw_left = (beats - k < 256) ? beats - k : 256;
        end
        exp_aw_addr.push_back(a);
        exp_aw_len.push_back(aw_left - 1);
      end
      aw_left--;
      si_off = int'(a[2:0]);
      mi_off = int'(a[1:0]);
      d = '0;
      s = '0;
      for (int m = 0; m < 4; m++) begin
        b = si_off + m - mi_off;
        if ((m >= mi_off) && (b < si_off + sbytes) && (b < 8)) begin
          d[8*m +: 8] = beat_data[j][8*b +: 8];
          s[m]        = 1'b1;
        end
      end
      exp_data.push_back(d);
      exp_strb.push_back(s);
      exp_last.push_back(k == beats - 1);
      nxt = (a & ~(32'(nbytes) - 32'd1)) + 32'(nbytes);
      if (!ds || (k == beats - 1) || (nxt[31:3] != a[31:3])) begin
        j++;
      end
      a = nxt;
    end
  endtask

  // --------------------------------------------------
  // Master-side checks
  // --------------------------------------------------
  task automatic check_aw(input int t);
    logic [31:0] ea;
    int          el;
    size_t       es;
    es = downsized(t) ? size_t'(2) : size_t'(st_size[t]);
    assert (exp_aw_addr.size() != 0) else begin
      $display("Master AW at %0t ns arrived after all expected AWs of test %0d", $time, t);
      err_cnt++;
    end
    if (exp_aw_addr.size() != 0) begin
      ea = exp_aw_addr.pop_front();
      el = exp_aw_len.pop_front();
      check_cnt++;
      assert ((mst_aw_id === st_id[t]) && (mst_aw_addr === ea) &&
              (mst_aw_len === len_t'(el)) && (mst_aw_size === es) &&
              (mst_aw_burst === burst_e'(st_burst[t]))) else begin
        $display("[FAIL] %0t ns: AW id %h addr %h len %0d size %0d, expected %h %h %0d %0d",
                 $time, mst_aw_id, mst_aw_addr, mst_aw_len, mst_aw_size,
                 st_id[t], ea, el, es);
        err_cnt++;
      end
    end
  endtask

  task automatic check_w();
    logic [31:0] ed;
    logic [3:0]  es;
    bit          el;
    assert (exp_data.size() != 0) else begin
      $display("Master W beat at %0t ns arrived after all expected beats", $time);
      err_cnt++;
    end
    if (exp_data.size() != 0) begin
      ed = exp_data.pop_front();
      es = exp_strb.pop_front();
      el = exp_last.pop_front();
      check_cnt++;
      assert ((mst_w_data === ed) && (mst_w_strb === es) && (mst_w_last === el)) else begin
        $display("[FAIL] %0t ns: W data %h strb %b last %b, expected %h %b %b",
                 $time, mst_w_data, mst_w_strb, mst_w_last, ed, es, el);
        err_cnt++;
      end
    end
  endtask

  function automatic logic draw_ready(int t);
    if (st_bp[t] == 0) begin
      return 1'b1;
    end
    return ($random(seed) & 3) != 0;
  endfunction

  // --------------------------------------------------
  // One test: AW, slave W beats, B
  // --------------------------------------------------
  task automatic run_test(input int t);
    int  aw_seen;
    int  w_seen;
    int  sw_idx;
    int  errs_before;
    bit  aw_done;
    bit  b_pending;
    bit  b_done;
    id_t b_id;
    for (int i = 0; i <= st_len[t]; i++) begin
      beat_data[i] = {$random(seed), $random(seed)};
    end
    build_expected(t);
    errs_before = err_cnt;
    aw_seen     = 0;
    w_seen      = 0;
    sw_idx      = 0;
    aw_done     = 1'b0;
    b_pending   = 1'b0;
    b_done      = 1'b0;
    b_id        = '0;
    while (!b_done) begin
      @(negedge clk);
      slv_aw_id    = st_id[t];
      slv_aw_addr  = st_addr[t];
      slv_aw_len   = len_t'(st_len[t]);
      slv_aw_size  = size_t'(st_size[t]);
      slv_aw_burst = burst_e'(st_burst[t]);
      slv_aw_cache = st_cache[t];
      slv_aw_valid = !aw_done;
      slv_w_strb   = '1;
      if (sw_idx <= st_len[t]) begin
        slv_w_valid = 1'b1;
        slv_w_data  = beat_data[sw_idx];
        slv_w_last  = (sw_idx == st_len[t]);
      end else begin
        slv_w_valid = 1'b0;
        slv_w_last  = 1'b0;
      end
      mst_aw_ready = draw_ready(t);
      mst_w_ready  = draw_ready(t);
      slv_b_ready  = draw_ready(t);
      mst_b_valid  = b_pending;
      mst_b_id     = b_id;
      mst_b_resp   = 2'b00;
      #(SETTLE);
      if (slv_aw_valid && slv_aw_ready) begin
        aw_done = 1'b1;
      end
      if (mst_aw_valid && mst_aw_ready) begin
        check_aw(t);
        b_id = mst_aw_id;
        aw_seen++;
      end
      if (mst_w_valid && mst_w_ready) begin
        check_w();
        w_seen++;
        b_pending = b_pending || mst_w_last;
      end
      if (slv_w_valid && slv_w_ready) begin
        sw_idx++;
      end
      assert ((slv_b_valid === mst_b_valid) && (mst_b_ready === slv_b_ready)) else begin
        $display("[FAIL] %0t ns: B valid or ready not passed straight through", $time);
        err_cnt++;
      end
      if (mst_b_valid && mst_b_ready) begin
        check_cnt++;
        assert ((slv_b_id === st_id[t]) && (slv_b_resp === 2'b00)) else begin
          $display("[FAIL] %0t ns: B id %h resp %0d, expected %h 0",
                   $time, slv_b_id, slv_b_resp, st_id[t]);
          err_cnt++;
        end
        b_done = 1'b1;
      end
    end
    check_cnt++;
    assert ((aw_seen == st_aw_cnt[t]) && (w_seen == narrow_beats(t)) &&
            (exp_aw_addr.size() == 0) && (sw_idx == st_len[t] + 1)) else begin
      $display("[FAIL] %0t ns: test %0d saw %0d AWs and %0d beats, expected %0d and %0d",
               $time, t, aw_seen, w_seen, st_aw_cnt[t], narrow_beats(t));
      err_cnt++;
    end
    $display("test %0d id %h addr %h: %0d AW, %0d narrow beats, %s", t, st_id[t], st_addr[t],
             aw_seen, w_seen, (err_cnt == errs_before) ? "ok" : "mismatch");
  endtask

  task automatic read_stim(output bit ok);
    int                 fd;
    int                 rc;
    logic [8*200-1:0]   header;
    int                 id;
    int                 size;
    int                 len;
    int                 burst;
    int                 cache;
    int                 bp;
    int                 awc;
    logic [31:0]        addr;
    n_tests = 0;
    fd      = $fopen("dwc_stim.txt", "r");
    ok      = (fd != 0);
    if (ok) begin
      rc = $fgets(header, fd);
      rc = $fgets(header, fd);
      rc = $fscanf(fd, "%h %h %d %d %d %h %d %d\n", id, addr, size, len, burst, cache, bp, awc);
      while ((rc == 8) && (n_tests < MAX_TESTS)) begin
        st_id[n_tests]     = id[3:0];
        st_addr[n_tests]   = addr;
        st_size[n_tests]   = size;
        st_len[n_tests]    = len;
        st_burst[n_tests]  = burst;
        st_cache[n_tests]  = cache[3:0];
        st_bp[n_tests]     = bp;
        st_aw_cnt[n_tests] = awc;
        n_tests++;
        rc = $fscanf(fd, "%h %h %d %d %d %h %d %d\n", id, addr, size, len, burst, cache, bp, awc);
      end
      $fclose(fd);
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    bit ok;
    int total;
    rst_n        = 1'b0;
    slv_aw_id    = '0;
    slv_aw_addr  = '0;
    slv_aw_len   = '0;
    slv_aw_size  = '0;
    slv_aw_burst = BURST_FIXED;
    slv_aw_cache = '0;
    slv_aw_valid = 1'b0;
    slv_w_data   = '0;
    slv_w_strb   = '0;
    slv_w_last   = 1'b0;
    slv_w_valid  = 1'b0;
    slv_b_ready  = 1'b0;
    mst_aw_ready = 1'b0;
    mst_w_ready  = 1'b0;
    mst_b_id     = '0;
    mst_b_resp   = '0;
    mst_b_valid  = 1'b0;
    read_stim(ok);
    if (!ok) begin
      $display("Error: could not open dwc_stim.txt for reading");
      err_cnt++;
    end
    total = 0;
    for (int t = 0; t < n_tests; t++) begin
      total += narrow_beats(t);
    end
    cycle_limit = 4 * total + 200;
    limit_set   = 1'b1;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    #(SETTLE);
    check_cnt++;
    assert ((slv_aw_ready === 1'b1) && (mst_aw_valid === 1'b0) && (mst_w_valid === 1'b0) &&
            (slv_b_valid === 1'b0)) else begin
      $display("[FAIL] %0t ns: control outputs wrong after reset", $time);
      err_cnt++;
    end
    $display("reset: outputs checked");
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    @(negedge clk);
    $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: dwc_stim.txt
# id addr size len burst cache bp aw_count (id, addr, cache in hex)
# burst 0 FIXED 1 INCR 2 WRAP; bp 1 turns on random ready stalls
1 00001000 3 3 1 2 0 1
2 00002004 3 3 1 3 0 1
3 00003000 3 3 1 0 0 1
4 00004008 2 5 1 2 0 1
5 00005006 1 4 1 2 0 1
6 00006000 3 1 2 2 0 1
7 00007004 2 3 0 2 0 1
8 00008000 3 200 1 2 0 2
9 00009004 3 200 1 2 0 2
a 0000a000 3 127 1 f 0 1
b 0000b000 3 15 1 2 1 1
c 0000c004 3 150 1 2 1 2

// File: sim.f
+incdir+.
dwc_pkg.sv
dwc_aw_decode.sv
dwc_burst_ctrl.sv
dwc_w_steer.sv
dwc_top.sv
tb_dwc.sv

// File: run_sim.sh
#!/bin/sh
# Build the downsizer testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_dwc -f sim.f -o tb_dwc
out=$(./obj_dir/tb_dwc)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
